/* build.f */
+incdir+source
+incdir+sim
source/tx_pkg.sv
source/ofdm_pkg.sv
source/iq_stream_if.sv
source/tx_mod_mapper.sv
source/tx_subcarrier_assembler.sv
source/tx_sample_stream.sv
source/obf_ofdm_tx.sv
sim/tb_obf_ofdm_tx.sv

/* Bender.yml */
package:
  name: obf_ofdm_tx

sources:
  - include_dirs:
      - source
    files:
      - source/tx_pkg.sv
      - source/ofdm_pkg.sv
      - source/iq_stream_if.sv
      - source/tx_mod_mapper.sv
      - source/tx_subcarrier_assembler.sv
      - source/tx_sample_stream.sv
      - source/obf_ofdm_tx.sv
  - target: simulation
    include_dirs:
      - source
      - sim
    files:
      - sim/tb_obf_ofdm_tx.sv

/* sim/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Sign from one bit, amplitude as given
function automatic int axis_sign(input logic b, input int amp);
    return b ? amp : -amp;
endfunction

// 16-QAM axis, bit 1 picks the sign and bit 0 the inner ring
function automatic int axis_qam16(input logic [1:0] b);
    int mag;
    mag = b[0] ? `QAM16_AMP1 : `QAM16_AMP3;
    return b[1] ? mag : -mag;
endfunction

function automatic iq_t expected_point(input logic [1:0] mod, input bits_t b);
    iq_t p;
    int  i_val;
    int  q_val;
    i_val = axis_sign(b[0], `BPSK_AMP);
    q_val = 0;
    if (mod == 2'd1) begin
        i_val = axis_sign(b[0], `QPSK_AMP);
        q_val = axis_sign(b[1], `QPSK_AMP);
    end else if (mod == 2'd2) begin
        i_val = axis_qam16(b[1:0]);
        q_val = axis_qam16(b[3:2]);
    end
    p.i = i_val[`IQ_W-1:0];
    p.q = q_val[`IQ_W-1:0];
    return p;
endfunction

// 0 null, 1 pilot, 2 data
function automatic int bin_kind(input int bin);
    if (bin == 0 || (bin >= `NULL_LO && bin <= `NULL_HI)) begin
        return 0;
    end
    if (bin == `PILOT_BIN_0 || bin == `PILOT_BIN_1 ||
        bin == `PILOT_BIN_2 || bin == `PILOT_BIN_3) begin
        return 1;
    end
    return 2;
endfunction

function automatic iq_t apply_mask(input int i_val, input int q_val, input logic [1:0] code);
    iq_t p;
    int  sh;
    case (shift_code_e'(code))
        SH_DIV8: sh = 3;
        SH_DIV2: sh = 1;
        SH_DIV4: sh = 2;
        default: sh = 0;
    endcase
    i_val = i_val >>> sh;
    q_val = q_val >>> sh;
    p.i = i_val[`IQ_W-1:0];
    p.q = q_val[`IQ_W-1:0];
    return p;
endfunction

// Fills the expected bin queue from the stored data groups
task automatic build_expected(input logic [1:0] mod, input int nsym,
                              input logic [`MASK_W-1:0] mask,
                              input logic [`SCRAM_W-1:0] seed);
    logic [`SCRAM_W-1:0] s;
    logic                p;
    int                  g;
    int                  i_val;
    int                  q_val;
    iq_t                 pt;
    s = seed;
    g = 0;
    exp_q.delete();
    exp_last_q.delete();
    for (int sym = 0; sym < nsym; sym++) begin
        p = s[6] ^ s[3];
        s = {s[5:0], p};
        for (int bin = 0; bin < `FFT_N; bin++) begin
            i_val = 0;
            q_val = 0;
            if (bin_kind(bin) == 1) begin
                i_val = int'(`PILOT_AMP);
                if (p) begin
                    i_val = -i_val;
                end
                // Last pilot runs with opposite sign
                if (bin == `PILOT_BIN_3) begin
                    i_val = -i_val;
                end
            end else if (bin_kind(bin) == 2) begin
                pt    = expected_point(mod, groups_q[g]);
                g     = g + 1;
                i_val = pt.i;
                q_val = pt.q;
            end
            exp_q.push_back(apply_mask(i_val, q_val, mask[2*bin +: 2]));
            exp_last_q.push_back(bin == `FFT_N - 1);
        end
    end
endtask

`endif

/* sim/tb_obf_ofdm_tx.sv */
`timescale 1ns/10ps
`include "tx_defs.svh"

module tb_obf_ofdm_tx;
    import tx_pkg::*;
    import ofdm_pkg::*;

    localparam int N_ROWS  = 7;
    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic [1:0]          mod;
        sym_cnt_t            nsym;
        logic [`MASK_W-1:0]  mask;
        logic [`SCRAM_W-1:0] seed;
        logic [15:0]         ready_pat;
        logic                rand_stall;
    } row_t;

    logic                    clk;
    logic                    reset_int;
    logic                    i_start;
    logic [1:0]              i_mod;
    logic [`SYM_CNT_W-1:0]   i_num_sym;
    logic [`MASK_W-1:0]      i_mask;
    logic [`SCRAM_W-1:0]     i_pilot_scram_init;
    logic                    i_bits_valid;
    logic                    o_bits_ready;
    logic [3:0]              i_bits;
    logic                    o_iq_valid;
    logic                    i_iq_ready;
    logic signed [`IQ_W-1:0] o_i;
    logic signed [`IQ_W-1:0] o_q;
    logic                    o_last_bin;
    logic                    o_done;
    logic                    o_busy;

    row_t  rows [N_ROWS];
    bits_t groups_q [$];
    iq_t   exp_q [$];
    logic  exp_last_q [$];

    `include "tb_ref_model.svh"

    obf_ofdm_tx u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_iq(input string name, input iq_t exp, input iq_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected I=%0d Q=%0d actual I=%0d Q=%0d",
                     $time, name, exp.i, exp.q, act.i, act.q);
            $display("STATUS: FAIL");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while %s at %0t", what, $time);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Mode, symbols, mask, pilot seed, ready pattern, random stall
    task automatic load_table();
        rows[0] = '{2'd0, 8'd2, 128'h0, 7'h7F, 16'hFFFF, 1'b0};
        rows[1] = '{2'd1, 8'd3, 128'h0, 7'h5A, 16'hFFFF, 1'b0};
        rows[2] = '{2'd2, 8'd2, 128'h0, 7'h01, 16'hFFFF, 1'b0};
        rows[3] = '{2'd2, 8'd4, {16{8'hE4}}, 7'h7F, 16'hFFFF, 1'b0};
        rows[4] = '{2'd1, 8'd2, {8{16'h1B6C}}, 7'h33, 16'hB5A3, 1'b0};
        rows[5] = '{2'd2, 8'd3, {16{8'hE4}}, 7'h4C, 16'hFFFF, 1'b1};
        // Code 3 runs as BPSK and zero symbols as one
        rows[6] = '{2'd3, 8'd0, {16{8'h39}}, 7'h12, 16'hFFFF, 1'b1};
    endtask

    task automatic start_packet(input row_t r);
        @(posedge clk);
        i_start            <= 1'b1;
        i_mod              <= r.mod;
        i_num_sym          <= r.nsym;
        i_mask             <= r.mask;
        i_pilot_scram_init <= r.seed;
        @(negedge clk);
        check_flag("o_busy", 1'b0, o_busy);
        @(posedge clk);
        // Second start with other values lands while busy
        i_mod              <= ~r.mod;
        i_num_sym          <= r.nsym + 8'd3;
        i_mask             <= ~r.mask;
        i_pilot_scram_init <= ~r.seed;
        @(negedge clk);
        check_flag("o_busy", 1'b1, o_busy);
        @(posedge clk);
        i_start <= 1'b0;
    endtask

    task automatic feed_bits(input int n);
        int k;
        int wait_cnt;
        k        = 0;
        wait_cnt = 0;
        @(posedge clk);
        i_bits_valid <= 1'b1;
        i_bits       <= groups_q[0];
        while (k < n) begin
            @(negedge clk);
            if (o_bits_ready) begin
                k        = k + 1;
                wait_cnt = 0;
            end else begin
                wait_cnt = wait_cnt + 1;
                if (wait_cnt > TIMEOUT) begin
                    report_timeout("waiting for o_bits_ready");
                end
            end
            @(posedge clk);
            if (k < n) begin
                i_bits <= groups_q[k];
            end else begin
                i_bits_valid <= 1'b0;
            end
        end
    endtask

    task automatic collect_bins(input row_t r, input int n);
        int  idx;
        int  cyc;
        int  wait_cnt;
        iq_t act;
        idx      = 0;
        cyc      = 0;
        wait_cnt = 0;
        while (idx < n) begin
            @(posedge clk);
            if (r.rand_stall) begin
                i_iq_ready <= ($urandom % 3) != 0;
            end else begin
                i_iq_ready <= r.ready_pat[cyc % 16];
            end
            cyc = cyc + 1;
            @(negedge clk);
            check_flag("o_done", 1'b0, o_done);
            if (o_iq_valid && i_iq_ready) begin
                act.i = o_i;
                act.q = o_q;
                check_iq("o_i/o_q", exp_q[idx], act);
                check_flag("o_last_bin", exp_last_q[idx], o_last_bin);
                idx      = idx + 1;
                wait_cnt = 0;
            end else begin
                wait_cnt = wait_cnt + 1;
                if (wait_cnt > TIMEOUT) begin
                    report_timeout("waiting for an output bin");
                end
            end
        end
        @(posedge clk);
        i_iq_ready <= 1'b0;
        // Cycle after the final transfer
        @(negedge clk);
        check_flag("o_done", 1'b1, o_done);
        check_flag("o_busy", 1'b0, o_busy);
        @(negedge clk);
        check_flag("o_done", 1'b0, o_done);
        check_flag("o_iq_valid", 1'b0, o_iq_valid);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int   nsym_eff;
        int   n_groups;
        row_t r;
        void'($urandom(73));
        reset_int          = 1'b1;
        i_start            = 1'b0;
        i_mod              = 2'd0;
        i_num_sym          = '0;
        i_mask             = '0;
        i_pilot_scram_init = '0;
        i_bits_valid       = 1'b0;
        i_bits             = '0;
        i_iq_ready         = 1'b0;
        load_table();

        repeat (9) @(posedge clk);
        @(negedge clk);
        check_flag("o_bits_ready", 1'b0, o_bits_ready);
        @(posedge clk);
        reset_int <= 1'b0;

        // Idle outputs before any start
        repeat (5) begin
            @(negedge clk);
            check_flag("o_iq_valid", 1'b0, o_iq_valid);
            check_flag("o_done", 1'b0, o_done);
            check_flag("o_busy", 1'b0, o_busy);
        end

        for (int ri = 0; ri < N_ROWS; ri++) begin
            r        = rows[ri];
            nsym_eff = (r.nsym == '0) ? 1 : int'(r.nsym);
            n_groups = nsym_eff * `N_DATA_SC;
            groups_q.delete();
            repeat (n_groups) groups_q.push_back(bits_t'($urandom));
            build_expected(r.mod, nsym_eff, r.mask, r.seed);
            start_packet(r);
            fork
                feed_bits(n_groups);
                collect_bins(r, exp_q.size());
            join
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* source/obf_ofdm_tx.sv */
`timescale 1ns/10ps
`include "tx_defs.svh"

module obf_ofdm_tx (
    input  logic                    clk,
    input  logic                    reset_int,
    input  logic                    i_start,
    input  logic [1:0]              i_mod,
    input  logic [`SYM_CNT_W-1:0]   i_num_sym,
    input  logic [`MASK_W-1:0]      i_mask,
    input  logic [`SCRAM_W-1:0]     i_pilot_scram_init,
    input  logic                    i_bits_valid,
    output logic                    o_bits_ready,
    input  logic [3:0]              i_bits,
    output logic                    o_iq_valid,
    input  logic                    i_iq_ready,
    output logic signed [`IQ_W-1:0] o_i,
    output logic signed [`IQ_W-1:0] o_q,
    output logic                    o_last_bin,
    output logic                    o_done,
    output logic                    o_busy
);
    import tx_pkg::*;

    mod_e mod_latched;
    logic map_valid;
    logic map_ready;
    iq_t  map_iq;

    iq_stream_if u_bin_if ();

    // Decode
    tx_mod_mapper u_mapper (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_mod        (mod_latched),
        .i_bits_valid (i_bits_valid),
        .o_bits_ready (o_bits_ready),
        .i_bits       (i_bits),
        .o_map_valid  (map_valid),
        .i_map_ready  (map_ready),
        .o_map_iq     (map_iq)
    );

    // Execute
    tx_subcarrier_assembler u_assembler (
        .clk                (clk),
        .reset_int          (reset_int),
        .i_start            (i_start),
        .i_mod              (i_mod),
        .i_num_sym          (i_num_sym),
        .i_mask             (i_mask),
        .i_pilot_scram_init (i_pilot_scram_init),
        .o_mod              (mod_latched),
        .o_busy             (o_busy),
        .i_map_valid        (map_valid),
        .o_map_ready        (map_ready),
        .i_map_iq           (map_iq),
        .out                (u_bin_if.src)
    );

    // Result
    tx_sample_stream u_stream (
        .clk        (clk),
        .reset_int  (reset_int),
        .in         (u_bin_if.snk),
        .o_iq_valid (o_iq_valid),
        .i_iq_ready (i_iq_ready),
        .o_i        (o_i),
        .o_q        (o_q),
        .o_last_bin (o_last_bin),
        .o_done     (o_done)
    );

endmodule

/* source/tx_sample_stream.sv */
`timescale 1ns/10ps
`include "tx_defs.svh"

module tx_sample_stream (
    input  logic                   clk,
    input  logic                   reset_int,
    iq_stream_if.snk               in,
    output logic                   o_iq_valid,
    input  logic                   i_iq_ready,
    output logic signed [`IQ_W-1:0] o_i,
    output logic signed [`IQ_W-1:0] o_q,
    output logic                   o_last_bin,
    output logic                   o_done
);
    import tx_pkg::*;

    typedef struct packed {
        iq_t  iq;
        logic last_bin;
        logic last_pkt;
    } entry_t;

    entry_t     ent_q [2];
    entry_t     head;
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       hold_last;
    logic       push;
    logic       pop;

    // Closed while full, or while the packet's final bin is still queued
    assign in.ready   = (count != 2'd2) && !hold_last;
    assign push       = in.valid && in.ready;
    assign o_iq_valid = (count != 2'd0);
    assign pop        = o_iq_valid && i_iq_ready;
    assign head       = ent_q[rd_ptr];

    //////////////////////////////
    // Two-entry buffer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            ent_q[wr_ptr] <= '{iq: in.iq, last_bin: in.last_bin, last_pkt: in.last_pkt};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_int) begin
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
            count     <= 2'd0;
            hold_last <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};

            if (push && in.last_pkt) begin
                hold_last <= 1'b1;
            end else if (pop && head.last_pkt) begin
                hold_last <= 1'b0;
            end

            // One-cycle pulse after the final bin leaves
            o_done <= pop && head.last_pkt;
        end
    end

    assign o_i        = head.iq.i;
    assign o_q        = head.iq.q;
    assign o_last_bin = head.last_bin;

endmodule

/* source/tx_subcarrier_assembler.sv */
`timescale 1ns/10ps
`include "tx_defs.svh"

module tx_subcarrier_assembler (
    input  logic                clk,
    input  logic                reset_int,
    input  logic                i_start,
    input  logic [1:0]          i_mod,
    input  ofdm_pkg::sym_cnt_t  i_num_sym,
    input  logic [`MASK_W-1:0]  i_mask,
    input  logic [`SCRAM_W-1:0] i_pilot_scram_init,
    output tx_pkg::mod_e        o_mod,
    output logic                o_busy,
    input  logic                i_map_valid,
    output logic                o_map_ready,
    input  tx_pkg::iq_t         i_map_iq,
    iq_stream_if.src            out
);
    import tx_pkg::*;
    import ofdm_pkg::*;

    localparam bin_idx_t BIN_LAST = bin_idx_t'(`FFT_N - 1);
    localparam logic signed [`IQ_W-1:0] PILOT_POS = `PILOT_AMP;

    asm_state_e          state;
    mod_e                mod_q;
    logic [`MASK_W-1:0]  mask_q;
    sym_cnt_t            num_sym_q;
    sym_cnt_t            sym_cnt;
    bin_idx_t            bin_cnt;
    logic [`SCRAM_W-1:0] scram_q;
    logic                pilot_neg;
    logic                pilot_bit;
    logic                start_acc;
    logic                drain_done;
    logic                last_sym;
    logic                is_null;
    logic                is_pilot;
    logic                is_data;
    logic                bin_go;
    iq_t                 raw_iq;
    iq_t                 shifted_iq;
    shift_code_e         coef;

    // Busy drops once the stream stage has sent the final bin
    assign drain_done = (state == AS_WAIT) && out.ready;
    assign o_busy     = (state != AS_IDLE) && !drain_done;
    assign start_acc  = i_start && !o_busy;
    assign last_sym   = (sym_cnt == num_sym_q - 1'b1);
    assign pilot_bit  = scram_q[`SCRAM_W-1] ^ scram_q[3];

    //////////////////////////////
    // Packet parameters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_int) begin
            mod_q     <= MOD_BPSK;
            num_sym_q <= sym_cnt_t'(1);
        end else if (start_acc) begin
            mod_q     <= (i_mod == 2'd3) ? MOD_BPSK : mod_e'(i_mod);
            // Zero symbols means one
            num_sym_q <= (i_num_sym == '0) ? sym_cnt_t'(1) : i_num_sym;
        end
    end

    always_ff @(posedge clk) begin
        if (start_acc) begin
            mask_q <= i_mask;
        end
    end

    // Pilot scrambler advances once per symbol
    always_ff @(posedge clk) begin
        if (reset_int) begin
            scram_q   <= '0;
            pilot_neg <= 1'b0;
        end else if (start_acc) begin
            scram_q <= i_pilot_scram_init;
        end else if (state == AS_PILOT) begin
            pilot_neg <= pilot_bit;
            scram_q   <= {scram_q[`SCRAM_W-2:0], pilot_bit};
        end
    end

    //////////////////////////////
    // Bin sequencing FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_int) begin
            state   <= AS_IDLE;
            sym_cnt <= '0;
            bin_cnt <= '0;
        end else begin
            case (state)
                AS_IDLE: begin
                    if (start_acc) begin
                        sym_cnt <= '0;
                        state   <= AS_PILOT;
                    end
                end
                AS_PILOT: begin
                    bin_cnt <= '0;
                    state   <= AS_BINS;
                end
                AS_BINS: begin
                    if (bin_go && bin_cnt == BIN_LAST) begin
                        if (last_sym) begin
                            state <= AS_WAIT;
                        end else begin
                            sym_cnt <= sym_cnt + 1'b1;
                            state   <= AS_PILOT;
                        end
                    end else if (bin_go) begin
                        bin_cnt <= bin_cnt + 1'b1;
                    end
                end
                AS_WAIT: begin
                    if (drain_done && start_acc) begin
                        sym_cnt <= '0;
                        state   <= AS_PILOT;
                    end else if (drain_done) begin
                        state <= AS_IDLE;
                    end
                end
                default: state <= AS_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Bin contents and mask
    //////////////////////////////

    always_comb begin
        is_null  = (bin_cnt == '0) || ((bin_cnt >= `NULL_LO) && (bin_cnt <= `NULL_HI));
        is_pilot = (bin_cnt == `PILOT_BIN_0) || (bin_cnt == `PILOT_BIN_1) ||
                   (bin_cnt == `PILOT_BIN_2) || (bin_cnt == `PILOT_BIN_3);
        is_data  = !is_null && !is_pilot;

        raw_iq = '0;
        if (is_pilot) begin
            // Last pilot carries the inverted polarity
            raw_iq.i = (pilot_neg ^ (bin_cnt == `PILOT_BIN_3)) ? -PILOT_POS : PILOT_POS;
        end else if (is_data) begin
            raw_iq = i_map_iq;
        end

        coef       = shift_code_e'(mask_q[{bin_cnt, 1'b0} +: 2]);
        shifted_iq = raw_iq;
        case (coef)
            SH_DIV8: begin
                shifted_iq.i = raw_iq.i >>> 3;
                shifted_iq.q = raw_iq.q >>> 3;
            end
            SH_DIV2: begin
                shifted_iq.i = raw_iq.i >>> 1;
                shifted_iq.q = raw_iq.q >>> 1;
            end
            SH_DIV4: begin
                shifted_iq.i = raw_iq.i >>> 2;
                shifted_iq.q = raw_iq.q >>> 2;
            end
            default: shifted_iq = raw_iq;
        endcase
    end

    // Data bins wait for a mapped point, others go straight out
    assign out.valid    = (state == AS_BINS) && (!is_data || i_map_valid);
    assign out.iq       = shifted_iq;
    assign out.last_bin = (bin_cnt == BIN_LAST);
    assign out.last_pkt = (bin_cnt == BIN_LAST) && last_sym;
    assign bin_go       = out.valid && out.ready;
    assign o_map_ready  = (state == AS_BINS) && is_data && out.ready;
    assign o_mod        = mod_q;

endmodule

/* source/tx_mod_mapper.sv */
`timescale 1ns/10ps
`include "tx_defs.svh"

module tx_mod_mapper (
    input  logic         clk,
    input  logic         reset_int,
    input  tx_pkg::mod_e  i_mod,
    input  logic         i_bits_valid,
    output logic         o_bits_ready,
    input  tx_pkg::bits_t i_bits,
    output logic         o_map_valid,
    input  logic         i_map_ready,
    output tx_pkg::iq_t   o_map_iq
);
    import tx_pkg::*;

    localparam logic signed [`IQ_W-1:0] BPSK_P  = `BPSK_AMP;
    localparam logic signed [`IQ_W-1:0] QPSK_P  = `QPSK_AMP;
    localparam logic signed [`IQ_W-1:0] QAM_P1  = `QAM16_AMP1;
    localparam logic signed [`IQ_W-1:0] QAM_P3  = `QAM16_AMP3;

    iq_t  mapped;
    iq_t  out_iq_q;
    iq_t  skid_iq_q;
    logic out_valid_q;
    logic skid_valid_q;
    logic rdy_q;
    logic accept_in;
    logic take_out;
    logic out_load;
    logic skid_load;
    logic skid_valid_nxt;

    // Gray-coded 16-QAM axis level
    function automatic logic signed [`IQ_W-1:0] qam16_level(input logic [1:0] b);
        case (b)
            2'b00:   return -QAM_P3;
            2'b01:   return -QAM_P1;
            2'b11:   return QAM_P1;
            default: return QAM_P3;
        endcase
    endfunction

    function automatic iq_t map_group(input mod_e mode, input bits_t b);
        iq_t p;
        p = '0;
        case (mode)
            MOD_QPSK: begin
                p.i = b[0] ? QPSK_P : -QPSK_P;
                p.q = b[1] ? QPSK_P : -QPSK_P;
            end
            MOD_QAM16: begin
                p.i = qam16_level(b[1:0]);
                p.q = qam16_level(b[3:2]);
            end
            // BPSK and the unused code
            default: p.i = b[0] ? BPSK_P : -BPSK_P;
        endcase
        return p;
    endfunction

    assign mapped    = map_group(i_mod, i_bits);
    assign accept_in = i_bits_valid && rdy_q;
    assign take_out  = out_valid_q && i_map_ready;

    //////////////////////////////
    // Skid stage
    //////////////////////////////

    always_comb begin
        out_load       = take_out || !out_valid_q;
        skid_load      = accept_in && !out_load;
        skid_valid_nxt = skid_valid_q ? !out_load : skid_load;
    end

    always_ff @(posedge clk) begin
        if (reset_int) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            rdy_q        <= 1'b0;
        end else begin
            if (out_load) begin
                out_valid_q <= skid_valid_q || accept_in;
            end
            skid_valid_q <= skid_valid_nxt;
            // Input stays open while the skid slot is free
            rdy_q        <= !skid_valid_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_iq_q <= skid_valid_q ? skid_iq_q : mapped;
        end
        if (skid_load) begin
            skid_iq_q <= mapped;
        end
    end

    assign o_bits_ready = rdy_q;
    assign o_map_valid  = out_valid_q;
    assign o_map_iq     = out_iq_q;

endmodule

/* source/iq_stream_if.sv */
`timescale 1ns/10ps

interface iq_stream_if;
    import tx_pkg::*;

    logic valid;
    logic ready;
    iq_t  iq;
    // Set on bin 63 of every symbol
    logic last_bin;
    // Set on the final bin of the packet
    logic last_pkt;

    modport src (
        output valid,
        output iq,
        output last_bin,
        output last_pkt,
        input  ready
    );

    modport snk (
        input  valid,
        input  iq,
        input  last_bin,
        input  last_pkt,
        output ready
    );

endinterface

/* source/ofdm_pkg.sv */
`include "tx_defs.svh"

package ofdm_pkg;

    // Bin position within one OFDM symbol
    typedef logic [$clog2(`FFT_N)-1:0] bin_idx_t;

    // Per-bin mask coefficient
    // Arithmetic right shift applied to I and Q
    typedef enum logic [1:0] {
        SH_NONE = 2'd0,
        SH_DIV8 = 2'd1,
        SH_DIV2 = 2'd2,
        SH_DIV4 = 2'd3
    } shift_code_e;

    // Number of OFDM symbols in a packet
    typedef logic [`SYM_CNT_W-1:0] sym_cnt_t;

endpackage

/* source/tx_pkg.sv */
`include "tx_defs.svh"

package tx_pkg;

    // One frequency-domain sample
    typedef struct packed {
        logic signed [`IQ_W-1:0] i;
        logic signed [`IQ_W-1:0] q;
    } iq_t;

    // Modulation codes, code 3 falls back to BPSK
    typedef enum logic [1:0] {
        MOD_BPSK  = 2'd0,
        MOD_QPSK  = 2'd1,
        MOD_QAM16 = 2'd2
    } mod_e;

    // Subcarrier assembler states
    typedef enum logic [1:0] {
        AS_IDLE  = 2'd0,
        AS_PILOT = 2'd1,
        AS_BINS  = 2'd2,
        AS_WAIT  = 2'd3
    } asm_state_e;

    // Data group, low bits used for BPSK and QPSK
    typedef logic [3:0] bits_t;

endpackage

/* source/tx_defs.svh */
`ifndef TX_DEFS_SVH
`define TX_DEFS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// One I or Q component
`define IQ_W        16
// Two mask bits per bin
`define MASK_W      128
`define SYM_CNT_W   8
// Pilot scrambler length
`define SCRAM_W     7

//////////////////////////////
// Symbol layout
//////////////////////////////

`define FFT_N       64
`define N_DATA_SC   48
`define PILOT_BIN_0 7
`define PILOT_BIN_1 21
`define PILOT_BIN_2 43
`define PILOT_BIN_3 57
// Sideband null range, DC is bin 0
`define NULL_LO     27
`define NULL_HI     37

//////////////////////////////
// Constellation amplitudes
//////////////////////////////

`define PILOT_AMP   16'h4000
`define BPSK_AMP    16384
`define QPSK_AMP    11585
`define QAM16_AMP1  5181
`define QAM16_AMP3  15543

`endif
